// File: seqPkg.sv
`default_nettype none

package seqPkg;

  localparam int pcWidth = 14;
  localparam int instrWidth = 18;
  localparam int bodyLenWidth = 4;
  localparam int iterWidth = 10;

  typedef enum logic [3:0] {
    opNop  = 4'h0,
    opJump = 4'h1,
    opCall = 4'h2,
    opRts  = 4'h3,
    opDo   = 4'h4
  } opcode_t;

  typedef enum logic [1:0] {
    selInc,
    selJump,
    selStack,
    selHold
  } seqSel_t;

  // jump target or loop setup, same 14 bits
  typedef union packed {
    logic [pcWidth-1:0] target;
    struct packed {
      logic [bodyLenWidth-1:0] bodyLen;
      logic [iterWidth-1:0]    iterCount;
    } loopArgs;
  } instrPayload_u;

  typedef struct packed {
    opcode_t       opcode;
    instrPayload_u payload;
  } instr_t;

endpackage

`default_nettype wire

// File: pcStackIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pcStackIf;

  logic                       push;
  logic                       pop;
  logic [seqPkg::pcWidth-1:0] pushData;
  logic [seqPkg::pcWidth-1:0] top;
  logic                       full;
  logic                       empty;
  logic                       has1;

  modport ctrl (output push, pop, pushData, input top, full, empty, has1);
  modport stack (input push, pop, pushData, output top, full, empty, has1);

endinterface

`default_nettype wire

// File: pcStackRam.sv
`timescale 1ns/1ps
`default_nettype none

module pcStackRam #(
  parameter int stackDepthLog2 = 4
) (
  input  wire logic                        PCSCLK,
  input  wire logic                        we,
  input  wire logic [stackDepthLog2-1:0]   wAddr,
  input  wire logic [seqPkg::pcWidth-1:0]  wData,
  input  wire logic [stackDepthLog2-1:0]   rAddr,
  output logic      [seqPkg::pcWidth-1:0]  rData
);

  localparam int depth = 2 ** stackDepthLog2;

  logic [seqPkg::pcWidth-1:0] cells [depth];

  always_ff @(posedge PCSCLK) begin
    if (we) begin
      cells[wAddr] <= wData;
    end
  end

  assign rData = cells[rAddr]; // top of stack, no read latency

endmodule

`default_nettype wire

// File: pcStack.sv
`timescale 1ns/1ps
`default_nettype none

module pcStack #(
  parameter int stackDepthLog2 = 4
) (
  input wire logic PCSCLK,
  input wire logic T_RST,
  input wire logic hold,
  pcStackIf.stack  stk
);

  // one extra bit so that all ones means empty
  logic [stackDepthLog2:0] ptr;
  logic [stackDepthLog2:0] ptrUp;
  logic [stackDepthLog2:0] ptrDown;
  logic                    doPush;
  logic                    doPop;

  assign doPush = stk.push && !stk.full;
  assign doPop  = stk.pop && !stk.empty;

  assign ptrUp   = ptr + 1'b1;
  assign ptrDown = ptr - 1'b1;

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (!hold) begin
      if (doPush) begin
        ptr <= ptrUp;
      end else if (doPop) begin
        ptr <= ptrDown;
      end
    end
  end

  assign stk.empty = ptr[stackDepthLog2];
  assign stk.full  = (ptr == {1'b0, {stackDepthLog2{1'b1}}});
  assign stk.has1  = (ptr == '0);

  pcStackRam #(
    .stackDepthLog2(stackDepthLog2)
  ) i_pcStackRam (
    .PCSCLK(PCSCLK),
    .we    (doPush && !hold),
    .wAddr (ptrUp[stackDepthLog2-1:0]), // write lands at the new top
    .wData (stk.pushData),
    .rAddr (ptr[stackDepthLog2-1:0]),
    .rData (stk.top)
  );

endmodule

`default_nettype wire

// File: loopCounter.sv
`timescale 1ns/1ps
`default_nettype none

module loopCounter (
  input  wire logic                          PCSCLK,
  input  wire logic                          T_RST,
  input  wire logic                          hold,
  input  wire logic [seqPkg::pcWidth-1:0]    pc,
  input  wire logic                          loopLoad,
  input  wire logic [seqPkg::iterWidth-1:0]  loadCount,
  input  wire logic [seqPkg::pcWidth-1:0]    loadEnd,
  input  wire logic                          loopIter,
  input  wire logic                          loopExit,
  output logic                               loopActive,
  output logic                               atEnd,
  output logic                               lastIter
);

  logic [seqPkg::iterWidth-1:0] count;
  logic [seqPkg::pcWidth-1:0]   endAddr;

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      loopActive <= 1'b0;
    end else if (!hold) begin
      if (loopLoad) begin
        loopActive <= 1'b1;
      end else if (loopExit) begin
        loopActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge PCSCLK) begin
    if (!hold) begin
      if (loopLoad) begin
        count   <= loadCount;
        endAddr <= loadEnd;
      end else if (loopIter) begin
        count <= count - 1'b1;
      end
    end
  end

  assign atEnd    = (pc == endAddr);
  assign lastIter = (count <= 1); // zero count runs once as well

endmodule

`default_nettype wire

// File: seqFsm.sv
`timescale 1ns/1ps
`default_nettype none

module seqFsm (
  input  wire logic                          PCSCLK,
  input  wire logic                          T_RST,
  input  wire logic                          hold,
  input  wire seqPkg::instr_t                instrWord,
  input  wire logic [seqPkg::pcWidth-1:0]    pc,
  input  wire logic                          loopActive,
  input  wire logic                          atEnd,
  input  wire logic                          lastIter,
  pcStackIf.ctrl                             ctl,
  output seqPkg::seqSel_t                    nextSel,
  output logic      [seqPkg::pcWidth-1:0]    jumpTarget,
  output logic                               loopLoad,
  output logic      [seqPkg::iterWidth-1:0]  loadCount,
  output logic      [seqPkg::pcWidth-1:0]    loadEnd,
  output logic                               loopIter,
  output logic                               loopExit,
  output logic                               overflow,
  output logic                               underflow
);

  typedef enum logic [1:0] {
    stReset,
    stRun,
    stInLoop
  } state_t;

  state_t                           state;
  state_t                           stateNext;
  logic   [seqPkg::bodyLenWidth-1:0] bodyLen;
  logic                             rtsEmpty;

  assign bodyLen    = instrWord.payload.loopArgs.bodyLen;
  assign jumpTarget = instrWord.payload.target;
  assign loadCount  = instrWord.payload.loopArgs.iterCount;
  assign loadEnd    = pc + {{(seqPkg::pcWidth - seqPkg::bodyLenWidth){1'b0}}, bodyLen};

  always_comb begin
    nextSel  = seqPkg::selInc;
    ctl.push = 1'b0;
    ctl.pop  = 1'b0;
    loopLoad = 1'b0;
    loopIter = 1'b0;
    loopExit = 1'b0;
    rtsEmpty = 1'b0;
    if (state == stReset) begin
      nextSel = seqPkg::selHold;
    end else if (loopActive && atEnd) begin
      // end marker beats the opcode
      if (!lastIter) begin
        nextSel  = seqPkg::selStack;
        loopIter = 1'b1;
      end else begin
        ctl.pop  = 1'b1;
        loopExit = 1'b1;
      end
    end else begin
      case (instrWord.opcode)
        seqPkg::opJump: nextSel = seqPkg::selJump;
        seqPkg::opCall: begin
          ctl.push = 1'b1;
          nextSel  = seqPkg::selJump;
        end
        seqPkg::opRts: begin
          ctl.pop = 1'b1; // stack drops it when empty
          if (ctl.empty) begin
            rtsEmpty = 1'b1;
          end else begin
            nextSel = seqPkg::selStack;
          end
        end
        seqPkg::opDo: begin
          if (state == stRun && bodyLen != '0) begin
            ctl.push = 1'b1;
            loopLoad = 1'b1;
          end
        end
        default: nextSel = seqPkg::selInc;
      endcase
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      stReset:  stateNext = stRun;
      stRun:    if (loopLoad) stateNext = stInLoop;
      stInLoop: if (loopExit) stateNext = stRun;
      default:  stateNext = stReset;
    endcase
  end

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      state     <= stReset;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else if (!hold) begin
      state <= stateNext;
      if (ctl.push && ctl.full) begin
        overflow <= 1'b1; // lost return address
      end
      if (rtsEmpty) begin
        underflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: pcGen.sv
`timescale 1ns/1ps
`default_nettype none

module pcGen (
  input  wire logic                        PCSCLK,
  input  wire logic                        T_RST,
  input  wire logic                        hold,
  input  wire seqPkg::seqSel_t             nextSel,
  input  wire logic [seqPkg::pcWidth-1:0]  jumpTarget,
  pcStackIf.ctrl                           ctl,
  output logic      [seqPkg::pcWidth-1:0]  pc
);

  logic [seqPkg::pcWidth-1:0] pcInc;
  logic [seqPkg::pcWidth-1:0] pcNext;

  assign pcInc        = pc + 1'b1;
  assign ctl.pushData = pcInc; // return address for CALL and DO

  always_comb begin
    case (nextSel)
      seqPkg::selInc:   pcNext = pcInc;
      seqPkg::selJump:  pcNext = jumpTarget;
      seqPkg::selStack: pcNext = ctl.top;
      default:          pcNext = pc;
    endcase
  end

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      pc <= '0;
    end else if (!hold) begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// File: seqTop.sv
`timescale 1ns/1ps
`default_nettype none

module seqTop #(
  parameter int stackDepthLog2 = 4
) (
  input  wire logic                           PCSCLK,
  input  wire logic                           T_RST,
  input  wire logic                           hold,
  input  wire logic [seqPkg::instrWidth-1:0]  instrWord,
  output logic      [seqPkg::pcWidth-1:0]     fetchAddr,
  output logic                                stackFull,
  output logic                                stackEmpty,
  output logic                                stackHas1,
  output logic                                overflow,
  output logic                                underflow,
  output logic                                loopActive
);

  pcStackIf stkBus ();

  logic [seqPkg::pcWidth-1:0]   pc;
  seqPkg::seqSel_t              nextSel;
  logic [seqPkg::pcWidth-1:0]   jumpTarget;
  logic                         loopLoad;
  logic [seqPkg::iterWidth-1:0] loadCount;
  logic [seqPkg::pcWidth-1:0]   loadEnd;
  logic                         loopIter;
  logic                         loopExit;
  logic                         atEnd;
  logic                         lastIter;

  pcStack #(
    .stackDepthLog2(stackDepthLog2)
  ) i_pcStack (
    .PCSCLK(PCSCLK),
    .T_RST (T_RST),
    .hold  (hold),
    .stk   (stkBus.stack)
  );

  loopCounter i_loopCounter (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .pc        (pc),
    .loopLoad  (loopLoad),
    .loadCount (loadCount),
    .loadEnd   (loadEnd),
    .loopIter  (loopIter),
    .loopExit  (loopExit),
    .loopActive(loopActive),
    .atEnd     (atEnd),
    .lastIter  (lastIter)
  );

  seqFsm i_seqFsm (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .instrWord (seqPkg::instr_t'(instrWord)),
    .pc        (pc),
    .loopActive(loopActive),
    .atEnd     (atEnd),
    .lastIter  (lastIter),
    .ctl       (stkBus.ctrl),
    .nextSel   (nextSel),
    .jumpTarget(jumpTarget),
    .loopLoad  (loopLoad),
    .loadCount (loadCount),
    .loadEnd   (loadEnd),
    .loopIter  (loopIter),
    .loopExit  (loopExit),
    .overflow  (overflow),
    .underflow (underflow)
  );

  pcGen i_pcGen (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .nextSel   (nextSel),
    .jumpTarget(jumpTarget),
    .ctl       (stkBus.ctrl), // drives pushData only
    .pc        (pc)
  );

  assign fetchAddr  = pc;
  assign stackFull  = stkBus.full;
  assign stackEmpty = stkBus.empty;
  assign stackHas1  = stkBus.has1;

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int halfPeriod = 50 // 100 ns period
) (
  output logic PCSCLK
);

  initial PCSCLK = 1'b0;

  always #(halfPeriod) PCSCLK = ~PCSCLK;

endmodule

`default_nettype wire

// File: seqTb.sv
`timescale 1ns/1ps
`default_nettype none

module seqTb;

  localparam int depth = 16;

  logic        PCSCLK;
  logic        T_RST;
  logic        hold;
  logic [17:0] instrWord;
  logic [13:0] fetchAddr;
  logic        stackFull;
  logic        stackEmpty;
  logic        stackHas1;
  logic        overflow;
  logic        underflow;
  logic        loopActive;

  logic [17:0] rom [0:16383];

  // reference model state
  logic [13:0] modelPc;
  logic [13:0] modelStack [0:depth-1];
  int          modelPtr;
  logic        modelLoop;
  int          modelCount;
  logic [13:0] modelEnd;
  logic        modelOvf;
  logic        modelUnf;
  logic        modelStarted;

  logic        rstSeen = 1'b1;
  logic        holdSeen = 1'b0;
  logic [17:0] instrSeen = '0;
  logic [19:0] lastOuts = '0;
  logic [13:0] lastAddr = '0;
  int          bodyEntries = 0;
  int          onceRuns = 0;
  int          mismatchCount = 0;
  int          otherCount = 0;
  int          seed = 32'h96517f14;
  logic        reached;

  tbClock clkGen (.PCSCLK(PCSCLK));

  seqTop i_seqTop (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .instrWord (instrWord),
    .fetchAddr (fetchAddr),
    .stackFull (stackFull),
    .stackEmpty(stackEmpty),
    .stackHas1 (stackHas1),
    .overflow  (overflow),
    .underflow (underflow),
    .loopActive(loopActive)
  );

  assign instrWord = rom[fetchAddr]; // ROM answers in the same cycle

  function automatic logic [17:0] makeBranch(input logic [3:0] op, input logic [13:0] target);
    return {op, target};
  endfunction

  function automatic logic [17:0] makeDo(input logic [3:0] len, input logic [9:0] count);
    return {seqPkg::opDo, len, count};
  endfunction

  task automatic loadProgram();
    for (int a = 0; a < 16384; a++) begin
      rom[a] = '0; // NOP everywhere
    end
    rom[14'h004] = makeBranch(seqPkg::opJump, 14'h010);
    // three-deep nesting
    rom[14'h010] = makeBranch(seqPkg::opCall, 14'h100);
    rom[14'h011] = makeBranch(seqPkg::opJump, 14'h200);
    rom[14'h100] = makeBranch(seqPkg::opCall, 14'h110);
    rom[14'h101] = makeBranch(seqPkg::opRts, 14'h000);
    rom[14'h110] = makeBranch(seqPkg::opCall, 14'h120);
    rom[14'h111] = makeBranch(seqPkg::opRts, 14'h000);
    rom[14'h121] = makeBranch(seqPkg::opRts, 14'h000);
    // 17 chained calls that unwind through the odd addresses
    for (int i = 0; i < 17; i++) begin
      rom[14'h200 + 2 * i] = makeBranch(seqPkg::opCall, 14'(14'h202 + 2 * i));
      rom[14'h201 + 2 * i] = makeBranch(seqPkg::opRts, 14'h000);
    end
    rom[14'h201] = makeBranch(seqPkg::opJump, 14'h030);
    rom[14'h222] = makeBranch(seqPkg::opRts, 14'h000);
    rom[14'h030] = makeBranch(seqPkg::opRts, 14'h000); // empty stack here
    rom[14'h031] = makeDo(4'd2, 10'd3);
    rom[14'h032] = makeBranch(seqPkg::opCall, 14'h300);
    rom[14'h300] = makeBranch(seqPkg::opRts, 14'h000);
    rom[14'h034] = makeDo(4'd1, 10'd0);
    rom[14'h036] = makeDo(4'd0, 10'd5); // zero length acts as a NOP
    rom[14'h037] = makeBranch(seqPkg::opJump, 14'h037);
  endtask

  function automatic void resetModel();
    modelPc      = '0;
    modelPtr     = -1;
    modelLoop    = 1'b0;
    modelCount   = 0;
    modelEnd     = '0;
    modelOvf     = 1'b0;
    modelUnf     = 1'b0;
    modelStarted = 1'b0;
  endfunction

  function automatic void pushModel(input logic [13:0] data);
    if (modelPtr == depth - 1) begin
      modelOvf = 1'b1;
    end else begin
      modelPtr++;
      modelStack[modelPtr] = data;
    end
  endfunction

  // one executed instruction by the sequencing rules
  function automatic void stepModel(input logic [17:0] w);
    logic [3:0]  op;
    logic [3:0]  len;
    logic [9:0]  cnt;
    logic [13:0] pcInc;
    op    = w[17:14];
    len   = w[13:10];
    cnt   = w[9:0];
    pcInc = modelPc + 14'd1;
    if (!modelStarted) begin
      modelStarted = 1'b1; // reset state cycle holds the PC
    end else if (modelLoop && modelPc == modelEnd) begin
      if (modelCount > 1) begin
        modelPc = modelStack[modelPtr];
        modelCount--;
      end else begin
        if (modelPtr >= 0) begin
          modelPtr--;
        end
        modelLoop = 1'b0;
        modelPc   = pcInc;
      end
    end else begin
      case (op)
        seqPkg::opJump: modelPc = w[13:0];
        seqPkg::opCall: begin
          pushModel(pcInc);
          modelPc = w[13:0];
        end
        seqPkg::opRts: begin
          if (modelPtr < 0) begin
            modelUnf = 1'b1;
            modelPc  = pcInc;
          end else begin
            modelPc = modelStack[modelPtr];
            modelPtr--;
          end
        end
        seqPkg::opDo: begin
          if (!modelLoop && len != 4'd0) begin
            pushModel(pcInc);
            modelLoop  = 1'b1;
            modelCount = (cnt == 10'd0) ? 1 : int'(cnt);
            modelEnd   = modelPc + {10'd0, len};
          end
          modelPc = pcInc;
        end
        default: modelPc = pcInc;
      endcase
    end
  endfunction

  task automatic checkSignal(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      mismatchCount++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkFlag(input logic cond, input string what);
    assert (cond) else begin
      otherCount++;
      $display("%s", what);
    end
  endtask

  task automatic waitForAddr(input logic [13:0] addr, input int limit, output logic ok);
    int n;
    n = 0;
    while (fetchAddr !== addr && n < limit) begin
      @(negedge PCSCLK);
      n++;
    end
    ok = (fetchAddr === addr);
    if (!ok) begin
      otherCount++;
      $display("timeout waiting for fetch address %h", addr);
    end
  endtask

  task automatic finishRun();
    $display("error count: %0d mismatches, %0d other errors", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // random stalls once reset is gone
  always @(posedge PCSCLK) begin
    if (!T_RST) begin
      hold <= (($random(seed) & 3) == 0);
    end
  end

  // model steps on what the last edge saw and then compares
  always @(negedge PCSCLK) begin
    if (rstSeen) begin
      resetModel();
    end else if (!holdSeen) begin
      stepModel(instrSeen);
    end
    checkSignal("fetchAddr", 16'(fetchAddr), 16'(modelPc));
    checkSignal("stackEmpty", 16'(stackEmpty), 16'(modelPtr < 0));
    checkSignal("stackFull", 16'(stackFull), 16'(modelPtr == depth - 1));
    checkSignal("stackHas1", 16'(stackHas1), 16'(modelPtr == 0));
    checkSignal("overflow", 16'(overflow), 16'(modelOvf));
    checkSignal("underflow", 16'(underflow), 16'(modelUnf));
    checkSignal("loopActive", 16'(loopActive), 16'(modelLoop));
    if (holdSeen && !rstSeen) begin
      assert ({fetchAddr, stackFull, stackEmpty, stackHas1, overflow, underflow, loopActive}
              === lastOuts) else begin
        mismatchCount++;
        $display("mismatch outputs under hold: got %h expected %h",
                 {fetchAddr, stackFull, stackEmpty, stackHas1, overflow, underflow, loopActive},
                 lastOuts);
      end
    end
    if (fetchAddr == 14'h032 && lastAddr != 14'h032) begin
      bodyEntries++;
    end
    if (fetchAddr == 14'h035 && !hold && !T_RST) begin
      onceRuns++; // the coming edge executes the body
    end
    lastOuts  = {fetchAddr, stackFull, stackEmpty, stackHas1, overflow, underflow, loopActive};
    lastAddr  = fetchAddr;
    rstSeen   = T_RST;
    holdSeen  = hold;
    instrSeen = rom[modelPc];
  end

  initial begin
    T_RST = 1'b1;
    hold  = 1'b0;
    loadProgram();
    repeat (9) @(posedge PCSCLK);
    @(negedge PCSCLK);
    checkSignal("fetchAddr", 16'(fetchAddr), 16'h0000);
    checkSignal("stackEmpty", 16'(stackEmpty), 16'h0001);
    @(posedge PCSCLK);
    T_RST <= 1'b0;
    waitForAddr(14'h010, 300, reached);
    if (reached) begin
      waitForAddr(14'h200, 300, reached);
    end
    if (reached) begin
      waitForAddr(14'h030, 400, reached);
    end
    if (reached) begin
      checkFlag(overflow === 1'b1, "overflow not set by the seventeenth call");
      waitForAddr(14'h031, 50, reached);
    end
    if (reached) begin
      checkFlag(underflow === 1'b1, "underflow not set by a return on an empty stack");
      waitForAddr(14'h034, 200, reached);
    end
    if (reached) begin
      checkFlag(bodyEntries == 3, "loop body with count 3 did not run three times");
      waitForAddr(14'h037, 100, reached);
    end
    if (reached) begin
      checkFlag(onceRuns == 1, "loop with count 0 did not run exactly once");
      repeat (20) @(negedge PCSCLK); // park loop still under random hold
    end
    finishRun();
  end

endmodule

`default_nettype wire

// File: sim.f
seqPkg.sv
pcStackIf.sv
pcStackRam.sv
pcStack.sv
loopCounter.sv
seqFsm.sv
pcGen.sv
seqTop.sv
tbClock.sv
seqTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module seqTb -o seqTbSim

./obj_dir/seqTbSim > sim.log 2>&1
cat sim.log

grep -q "^ALL CHECKS PASSED$" sim.log
